// ==== hdl/elem_pkg.sv ====
// shared types for the element reduction unit
// imported by the RTL blocks and by the testbench checker

package elem_pkg;

    ////////////////////
    // data widths

    // one element or scalar word
    typedef logic [31:0] elem_t;

    // vector length in elements
    typedef logic [7:0] vl_t;

    // element width selection
    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10
    } sew_e;

    // scalar result operations
    typedef enum logic [3:0] {
        OP_REDSUM  = 4'd0,
        OP_REDAND  = 4'd1,
        OP_REDOR   = 4'd2,
        OP_REDXOR  = 4'd3,
        OP_REDMINU = 4'd4,
        OP_REDMIN  = 4'd5,
        OP_REDMAXU = 4'd6,
        OP_REDMAX  = 4'd7,
        OP_POPC    = 4'd8,
        OP_FIRST   = 4'd9
    } elem_op_e;

    ////////////////////
    // grouped signals

    typedef struct packed {
        sew_e sew;
        vl_t  vl;
    } elem_cfg_t;

    // one element step handed from the sequencer to the ALU
    typedef struct packed {
        logic     first;
        logic     last;
        logic     active;
        elem_op_e op;
    } elem_beat_t;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'b00,
        ST_RUN     = 2'b01,
        ST_DONE    = 2'b10,
        ST_RELEASE = 2'b11
    } seq_state_e;

    // number of elements of the given width in one vector register
    function automatic vl_t vlmax(sew_e sew, int unsigned vreg_w);
        vl_t n;
        case (sew)
            SEW_8:   n = vl_t'(vreg_w / 8);
            SEW_16:  n = vl_t'(vreg_w / 16);
            default: n = vl_t'(vreg_w / 32);
        endcase
        return n;
    endfunction

    // popc and first step through the register one mask bit at a time
    function automatic logic is_mask_op(elem_op_e op);
        return (op == OP_POPC) || (op == OP_FIRST);
    endfunction

endpackage

// ==== hdl/elem_cfg_regs.sv ====
// configuration register of the element unit
// holds SEW and a vl clamped to the register capacity for that SEW

`timescale 1ns/1ps

module elem_cfg_regs import elem_pkg::*; #(
    parameter int unsigned VREG_W = 128
) (
    input  logic      clk_i,
    input  logic      async_rst_ni,

    input  logic      cfg_we_i,
    input  elem_cfg_t cfg_wdata_i,
    output elem_cfg_t cfg_o
);

    elem_cfg_t cfg_q;
    elem_cfg_t cfg_d;
    vl_t       vl_max;

    // capacity for the SEW being written, not the stored one
    assign vl_max = vlmax(cfg_wdata_i.sew, VREG_W);

    always_comb begin
        cfg_d = cfg_q;
        if (cfg_we_i) begin
            cfg_d.sew = cfg_wdata_i.sew;
            if (cfg_wdata_i.vl > vl_max) begin
                cfg_d.vl = vl_max;
            end else begin
                cfg_d.vl = cfg_wdata_i.vl;
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            cfg_q.sew <= SEW_8;
            cfg_q.vl  <= '0;
        end else begin
            cfg_q <= cfg_d;
        end
    end

    // feeds both the sequencer and the readback port
    assign cfg_o = cfg_q;

endmodule

// ==== hdl/elem_sequencer.sv ====
// operation sequencer of the element unit
// runs the req/ack handshake and issues one element beat per cycle to the ALU

`timescale 1ns/1ps

module elem_sequencer import elem_pkg::*; #(
    parameter int unsigned VREG_W = 128
) (
    input  logic       clk_i,
    input  logic       async_rst_ni,

    input  logic       op_req_i,
    output logic       op_ack_o,
    input  elem_op_e   op_i,
    input  elem_cfg_t  cfg_i,

    input  logic       alu_done_i,

    output logic       load_o,
    output logic       shift_o,
    output sew_e       sew_o,
    output logic       beat_valid_o,
    output elem_beat_t beat_o
);

    seq_state_e state_q, state_d;
    elem_op_e   op_q;
    elem_cfg_t  cfg_q;
    vl_t        cnt_q;
    vl_t        num_steps;
    logic       accept;
    logic       last_step;

    ////////////////////
    // step control

    assign accept = (state_q == ST_IDLE) && op_req_i;

    // mask ops walk every mask bit, reductions walk vlmax elements
    assign num_steps = is_mask_op(op_q) ? vl_t'(VREG_W / 8) : vlmax(cfg_q.sew, VREG_W);
    assign last_step = (cnt_q == num_steps - vl_t'(1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:    if (op_req_i)   state_d = ST_RUN;
            ST_RUN:     if (last_step)  state_d = ST_DONE;
            ST_DONE:    if (alu_done_i) state_d = ST_RELEASE;
            ST_RELEASE: if (!op_req_i)  state_d = ST_IDLE;
            default:    state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q   <= ST_IDLE;
            op_q      <= OP_REDSUM;
            cfg_q.sew <= SEW_8;
            cfg_q.vl  <= '0;
            cnt_q     <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                // later config writes leave the running operation alone
                op_q  <= op_i;
                cfg_q <= cfg_i;
                cnt_q <= '0;
            end else if (state_q == ST_RUN) begin
                cnt_q <= cnt_q + vl_t'(1);
            end
        end
    end

    ////////////////////
    // outputs

    // shifter takes the vector on the accepting edge
    assign load_o       = accept;
    assign shift_o      = (state_q == ST_RUN);
    assign sew_o        = cfg_q.sew;
    assign beat_valid_o = (state_q == ST_RUN);

    always_comb begin
        beat_o.first  = (cnt_q == '0);
        beat_o.last   = last_step;
        // elements at index vl and above do not take part
        beat_o.active = (cnt_q < cfg_q.vl);
        beat_o.op     = op_q;
    end

    // held until the requester drops its request
    assign op_ack_o = (state_q == ST_RELEASE);

endmodule

// ==== hdl/elem_operand_shift.sv ====
// operand shift register of the element unit
// loads one vector register and presents one element or mask bit per step

`timescale 1ns/1ps

module elem_operand_shift import elem_pkg::*; #(
    parameter int unsigned VREG_W = 128
) (
    input  logic              clk_i,

    input  logic              load_i,
    input  logic              shift_i,
    input  sew_e              sew_i,
    input  logic              mask_mode_i,
    input  logic [VREG_W-1:0] vec_i,

    output elem_t             elem_o
);

    logic [VREG_W-1:0] vec_q;
    logic [VREG_W-1:0] vec_shifted;

    // move down by one element, or one bit for mask ops
    always_comb begin
        if (mask_mode_i) begin
            vec_shifted = vec_q >> 1;
        end else begin
            case (sew_i)
                SEW_8:   vec_shifted = vec_q >> 8;
                SEW_16:  vec_shifted = vec_q >> 16;
                default: vec_shifted = vec_q >> 32;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            vec_q <= vec_i;
        end else if (shift_i) begin
            vec_q <= vec_shifted;
        end
    end

    ////////////////////
    // element output

    always_comb begin
        if (mask_mode_i) begin
            elem_o = {31'b0, vec_q[0]};
        end else begin
            case (sew_i)
                SEW_8:   elem_o = {24'b0, vec_q[7:0]};
                SEW_16:  elem_o = {16'b0, vec_q[15:0]};
                default: elem_o = vec_q[31:0];
            endcase
        end
    end

endmodule

// ==== hdl/elem_reduce_alu.sv ====
// reduction ALU of the element unit
// folds one element per beat into the accumulator and extends the final result

`timescale 1ns/1ps

module elem_reduce_alu import elem_pkg::*; (
    input  logic       clk_i,
    input  logic       async_rst_ni,

    input  logic       beat_valid_i,
    input  elem_beat_t beat_i,
    input  sew_e       sew_i,
    input  elem_t      elem_i,
    input  elem_t      scalar_i,

    output elem_t      result_o,
    output logic       done_o
);

    elem_t acc_q, acc_d;
    elem_t base;
    vl_t   idx_q, cur_idx;
    logic  done_q;
    logic  take_elem;
    logic  signed [32:0] elem_x, base_x, final_x;

    // widen the low SEW bits to 33 bits so one signed compare covers both kinds
    function automatic logic signed [32:0] sew_ext(elem_t v, sew_e sew, logic sgn);
        logic signed [32:0] r;
        case (sew)
            SEW_8:   r = {{25{sgn & v[7]}}, v[7:0]};
            SEW_16:  r = {{17{sgn & v[15]}}, v[15:0]};
            default: r = {sgn & v[31], v};
        endcase
        return r;
    endfunction

    ////////////////////
    // accumulate

    assign cur_idx = beat_i.first ? '0 : idx_q;

    always_comb begin
        // seed on the first beat
        if (beat_i.first) begin
            case (beat_i.op)
                OP_POPC:  base = '0;
                OP_FIRST: base = '1;
                default:  base = scalar_i;
            endcase
        end else begin
            base = acc_q;
        end

        elem_x    = sew_ext(elem_i, sew_i, beat_i.op inside {OP_REDMIN, OP_REDMAX});
        base_x    = sew_ext(base, sew_i, beat_i.op inside {OP_REDMIN, OP_REDMAX});
        take_elem = 1'b0;
        acc_d     = base;

        if (beat_i.active) begin
            case (beat_i.op)
                OP_REDSUM:  acc_d = base + elem_i;
                OP_REDAND:  acc_d = base & elem_i;
                OP_REDOR:   acc_d = base | elem_i;
                OP_REDXOR:  acc_d = base ^ elem_i;
                OP_REDMINU,
                OP_REDMIN:  take_elem = (elem_x < base_x);
                OP_REDMAXU,
                OP_REDMAX:  take_elem = (elem_x > base_x);
                OP_POPC:    acc_d = base + elem_t'(elem_i[0]);
                // all ones means no set bit seen yet
                OP_FIRST:   if (base == '1 && elem_i[0]) acc_d = elem_t'(cur_idx);
                default:    acc_d = base;
            endcase
            if (take_elem) begin
                acc_d = elem_i;
            end
        end

        // final extension, signed only for min and max
        final_x = sew_ext(acc_d, sew_i, beat_i.op inside {OP_REDMIN, OP_REDMAX});
        if (beat_i.last && !is_mask_op(beat_i.op)) begin
            acc_d = final_x[31:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (beat_valid_i) begin
            acc_q <= acc_d;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            idx_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= beat_valid_i & beat_i.last;
            if (beat_valid_i) begin
                idx_q <= cur_idx + vl_t'(1);
            end
        end
    end

    assign result_o = acc_q;
    assign done_o   = done_q;

endmodule

// ==== hdl/elem_unit.sv ====
// top level of the element reduction unit
// config port plus a four-phase req/ack port returning one scalar per operation

`timescale 1ns/1ps

module elem_unit import elem_pkg::*; #(
    parameter int unsigned VREG_W = 128
) (
    input  logic              clk_i,
    input  logic              async_rst_ni,

    input  logic              cfg_we_i,
    input  elem_cfg_t         cfg_wdata_i,
    output elem_cfg_t         cfg_rdata_o,

    input  logic              op_req_i,
    output logic              op_ack_o,
    input  elem_op_e          op_i,
    input  logic [VREG_W-1:0] vec_i,
    input  elem_t             scalar_i,
    output elem_t             result_o
);

    elem_cfg_t  cfg;
    logic       load;
    logic       shift;
    sew_e       sew;
    logic       beat_valid;
    elem_beat_t beat;
    elem_t      elem;
    logic       alu_done;
    logic       mask_mode;

    // shifter steps by one bit while a mask op is running
    assign mask_mode = is_mask_op(beat.op);

    ////////////////////
    // instances

    elem_cfg_regs #(.VREG_W(VREG_W)) u_cfg_regs (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .cfg_we_i     (cfg_we_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .cfg_o        (cfg)
    );
    assign cfg_rdata_o = cfg;

    elem_sequencer #(.VREG_W(VREG_W)) u_sequencer (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .op_req_i     (op_req_i),
        .op_ack_o     (op_ack_o),
        .op_i         (op_i),
        .cfg_i        (cfg),
        .alu_done_i   (alu_done),
        .load_o       (load),
        .shift_o      (shift),
        .sew_o        (sew),
        .beat_valid_o (beat_valid),
        .beat_o       (beat)
    );

    elem_operand_shift #(.VREG_W(VREG_W)) u_operand_shift (
        .clk_i       (clk_i),
        .load_i      (load),
        .shift_i     (shift),
        .sew_i       (sew),
        .mask_mode_i (mask_mode),
        .vec_i       (vec_i),
        .elem_o      (elem)
    );

    elem_reduce_alu u_reduce_alu (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .beat_valid_i (beat_valid),
        .beat_i       (beat),
        .sew_i        (sew),
        .elem_i       (elem),
        .scalar_i     (scalar_i),
        .result_o     (result_o),
        .done_o       (alu_done)
    );

endmodule

// ==== dv/elem_unit_checker.sv ====
// result and readback checker for the element unit testbench
// samples the DUT ports on the falling clock edge and counts mismatches

`timescale 1ns/1ps

module elem_unit_checker import elem_pkg::*; (
    input  logic      clk_i,
    input  logic      async_rst_ni,

    input  logic      op_req_i,
    input  logic      op_ack_i,
    input  elem_t     result_i,
    input  elem_t     exp_result_i,

    input  elem_cfg_t cfg_rdata_i,
    input  logic      cfg_check_i,
    input  elem_cfg_t exp_cfg_i,

    output int        result_errs_o,
    output int        cfg_errs_o,
    output int        proto_errs_o,
    output int        checks_o
);

    int    result_errs = 0;
    int    cfg_errs    = 0;
    int    proto_errs  = 0;
    int    checks      = 0;
    logic  ack_q       = 1'b0;
    logic  req_q       = 1'b0;
    elem_t result_q    = '0;

    always @(negedge clk_i) begin
        if (!async_rst_ni) begin
            ack_q = 1'b0;
            req_q = 1'b0;
        end else begin
            // result is final for the whole time ack is high
            if (op_ack_i) begin
                checks++;
                if (result_i !== exp_result_i) begin
                    result_errs++;
                    $display("Fail result_o got %h expected %h", result_i, exp_result_i);
                end
                if (ack_q && result_i !== result_q) begin
                    proto_errs++;
                    $display("result_o changed while op_ack_o was high");
                end
            end

            ////////////////////
            // four-phase order
            if (op_ack_i && !ack_q && !req_q) begin
                proto_errs++;
                $display("op_ack_o rose without a pending request");
            end
            if (!op_ack_i && ack_q && req_q) begin
                proto_errs++;
                $display("op_ack_o fell while op_req_i was still high");
            end
            // ack drops in the cycle after the request is seen low
            if (op_ack_i && ack_q && !req_q) begin
                proto_errs++;
                $display("op_ack_o stayed high after op_req_i fell");
            end

            if (cfg_check_i && cfg_rdata_i !== exp_cfg_i) begin
                cfg_errs++;
                $display("Fail cfg_rdata_o got %h expected %h", cfg_rdata_i, exp_cfg_i);
            end

            ack_q    = op_ack_i;
            req_q    = op_req_i;
            result_q = result_i;
        end
    end

    assign result_errs_o = result_errs;
    assign cfg_errs_o    = cfg_errs;
    assign proto_errs_o  = proto_errs;
    assign checks_o      = checks;

endmodule

// ==== dv/elem_unit_tb.sv ====
// testbench for the element reduction unit
// drives config writes and req/ack operations, the checker module compares

`timescale 1ns/1ps

module elem_unit_tb import elem_pkg::*; ();

    localparam int unsigned VREG_W     = 128;
    localparam int          DRIVE_DLY  = 2;
    localparam int          WAIT_LIMIT = 200;

    logic              clk;
    logic              async_rst_n;
    logic              cfg_we;
    elem_cfg_t         cfg_wdata;
    elem_cfg_t         cfg_rdata;
    logic              op_req;
    logic              op_ack;
    elem_op_e          op;
    logic [VREG_W-1:0] vec;
    elem_t             scalar;
    elem_t             result;

    elem_t             exp_result;
    logic              cfg_check;
    elem_cfg_t         exp_cfg;
    elem_cfg_t         model_cfg;
    int                result_errs;
    int                cfg_errs;
    int                proto_errs;
    int                checks;
    int                timeout_errs;
    logic              timed_out;
    int                seed;

    elem_unit #(.VREG_W(VREG_W)) uut (
        .clk_i        (clk),
        .async_rst_ni (async_rst_n),
        .cfg_we_i     (cfg_we),
        .cfg_wdata_i  (cfg_wdata),
        .cfg_rdata_o  (cfg_rdata),
        .op_req_i     (op_req),
        .op_ack_o     (op_ack),
        .op_i         (op),
        .vec_i        (vec),
        .scalar_i     (scalar),
        .result_o     (result)
    );

    elem_unit_checker u_checker (
        .clk_i         (clk),
        .async_rst_ni  (async_rst_n),
        .op_req_i      (op_req),
        .op_ack_i      (op_ack),
        .result_i      (result),
        .exp_result_i  (exp_result),
        .cfg_rdata_i   (cfg_rdata),
        .cfg_check_i   (cfg_check),
        .exp_cfg_i     (exp_cfg),
        .result_errs_o (result_errs),
        .cfg_errs_o    (cfg_errs),
        .proto_errs_o  (proto_errs),
        .checks_o      (checks)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // reference model

    function automatic int unsigned sew_bits(sew_e s);
        case (s)
            SEW_8:   return 8;
            SEW_16:  return 16;
            default: return 32;
        endcase
    endfunction

    function automatic vl_t clamp_vl(sew_e s, vl_t v);
        vl_t cap;
        cap = vl_t'(VREG_W / sew_bits(s));
        return (v > cap) ? cap : v;
    endfunction

    // two's complement value of the low w bits
    function automatic longint as_signed(elem_t v, int unsigned w);
        longint r;
        r = longint'(v);
        if (v[w-1]) r = r - (longint'(1) << w);
        return r;
    endfunction

    function automatic elem_t ref_result(elem_op_e o, sew_e s, vl_t vl,
                                         logic [VREG_W-1:0] v, elem_t sc);
        int unsigned w;
        elem_t       mask;
        elem_t       acc;
        elem_t       e;
        w    = sew_bits(s);
        mask = (w == 32) ? '1 : (elem_t'(1) << w) - elem_t'(1);
        if (o == OP_POPC) begin
            acc = '0;
            for (int i = 0; i < int'(vl); i++) acc = acc + elem_t'(v[i]);
            return acc;
        end
        if (o == OP_FIRST) begin
            for (int i = 0; i < int'(vl); i++) if (v[i]) return elem_t'(i);
            return '1;
        end
        acc = sc & mask;
        for (int i = 0; i < int'(vl); i++) begin
            e = elem_t'(v >> (i * w)) & mask;
            case (o)
                OP_REDSUM:  acc = (acc + e) & mask;
                OP_REDAND:  acc = acc & e;
                OP_REDOR:   acc = acc | e;
                OP_REDXOR:  acc = acc ^ e;
                OP_REDMINU: if (e < acc) acc = e;
                OP_REDMAXU: if (e > acc) acc = e;
                OP_REDMIN:  if (as_signed(e, w) < as_signed(acc, w)) acc = e;
                default:    if (as_signed(e, w) > as_signed(acc, w)) acc = e;
            endcase
        end
        if (o == OP_REDMIN || o == OP_REDMAX) acc = elem_t'(as_signed(acc, w));
        return acc;
    endfunction

    function automatic logic [VREG_W-1:0] rand_vec();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // vl up to 19 so some writes get clamped
    function automatic vl_t rand_vl();
        return vl_t'({$random(seed)} % 20);
    endfunction

    ////////////////////
    // stimulus tasks

    task automatic write_cfg(input sew_e s, input vl_t v);
        cfg_we        = 1'b1;
        cfg_wdata.sew = s;
        cfg_wdata.vl  = v;
        @(posedge clk);
        #DRIVE_DLY;
        cfg_we        = 1'b0;
        model_cfg.sew = s;
        model_cfg.vl  = clamp_vl(s, v);
        exp_cfg       = model_cfg;
        cfg_check     = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        cfg_check     = 1'b0;
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (op_ack !== level && n < WAIT_LIMIT) begin
            @(posedge clk);
            #DRIVE_DLY;
            n++;
        end
        if (op_ack !== level) begin
            $display("timeout: op_ack_o did not go to %0d within %0d cycles", level, WAIT_LIMIT);
            timeout_errs++;
            timed_out = 1'b1;
        end
    endtask

    // expected value is posted before the request goes up
    task automatic start_op(input elem_op_e o, input logic [VREG_W-1:0] v, input elem_t s);
        exp_result = ref_result(o, model_cfg.sew, model_cfg.vl, v, s);
        op         = o;
        vec        = v;
        scalar     = s;
        op_req     = 1'b1;
    endtask

    task automatic finish_op(input int hold);
        wait_ack(1'b1);
        repeat (hold) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        op_req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic run_op(input elem_op_e o, input logic [VREG_W-1:0] v, input elem_t s,
                          input int hold);
        if (timed_out) return;
        start_op(o, v, s);
        finish_op(hold);
    endtask

    task automatic check_clamp();
        for (int s = 0; s < 3; s++) begin
            write_cfg(sew_e'(2'(s)), 8'd200);
            write_cfg(sew_e'(2'(s)), 8'd3);
        end
    endtask

    task automatic check_reductions(input int first_op, input int last_op);
        for (int s = 0; s < 3; s++) begin
            for (int k = first_op; k <= last_op; k++) begin
                // vl 0 returns the seed scalar extended from SEW
                write_cfg(sew_e'(2'(s)), 8'd0);
                run_op(elem_op_e'(4'(k)), rand_vec(), $random(seed), 0);
                for (int n = 0; n < 5; n++) begin
                    write_cfg(sew_e'(2'(s)), rand_vl());
                    run_op(elem_op_e'(4'(k)), rand_vec(), $random(seed), 0);
                end
            end
        end
    endtask

    task automatic check_mask_ops();
        logic [VREG_W-1:0] m;
        for (int s = 0; s < 3; s++) begin
            for (int k = 8; k <= 9; k++) begin
                write_cfg(sew_e'(2'(s)), 8'd16);
                run_op(elem_op_e'(4'(k)), '0, $random(seed), 0);
                for (int n = 0; n < 6; n++) begin
                    // sparse masks push the first set bit further up
                    m = rand_vec();
                    if (n % 2 == 1) m = m & rand_vec() & rand_vec();
                    write_cfg(sew_e'(2'(s)), rand_vl());
                    run_op(elem_op_e'(4'(k)), m, $random(seed), 0);
                end
            end
        end
    endtask

    task automatic check_handshake();
        logic [VREG_W-1:0] v;
        elem_t             s;
        v = rand_vec();
        s = $random(seed);
        write_cfg(SEW_32, 8'd4);
        if (timed_out) return;
        start_op(OP_REDSUM, v, s);
        // reconfigure while the sum is still stepping
        @(posedge clk);
        #DRIVE_DLY;
        write_cfg(SEW_8, 8'd16);
        finish_op(3);
        run_op(OP_REDSUM, v, s, 2);
        run_op(OP_REDMAX, v, s, 5);
    endtask

    ////////////////////
    // main sequence

    initial begin
        seed          = 45831;
        async_rst_n   = 1'b0;
        cfg_we        = 1'b0;
        cfg_wdata     = '0;
        op_req        = 1'b0;
        op            = OP_REDSUM;
        vec           = '0;
        scalar        = '0;
        exp_result    = '0;
        cfg_check     = 1'b0;
        model_cfg.sew = SEW_8;
        model_cfg.vl  = '0;
        exp_cfg       = model_cfg;
        timeout_errs  = 0;
        timed_out     = 1'b0;

        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        async_rst_n = 1'b1;

        // reset value of the config register
        cfg_check = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        cfg_check = 1'b0;

        check_clamp();
        check_reductions(0, 3);
        check_reductions(4, 7);
        check_mask_ops();
        check_handshake();
        repeat (4) @(posedge clk);

        $display("errors: result %0d, config %0d, handshake %0d, timeout %0d (%0d samples)",
                 result_errs, cfg_errs, proto_errs, timeout_errs, checks);
        if (result_errs + cfg_errs + proto_errs + timeout_errs == 0 && checks > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== elem_unit.f ====
hdl/elem_pkg.sv
hdl/elem_cfg_regs.sv
hdl/elem_sequencer.sv
hdl/elem_operand_shift.sv
hdl/elem_reduce_alu.sv
hdl/elem_unit.sv
dv/elem_unit_checker.sv
dv/elem_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the element unit testbench

TOP = elem_unit_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f elem_unit.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

lint:
	verilator --lint-only --timing -f elem_unit.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
